/* compile.f */
hdl/saturn_cpu_pkg.sv
hdl/saturn_dbg_pkg.sv
hdl/saturn_phase_gen.sv
hdl/saturn_debugger.sv
hdl/saturn_dbg_line_buffer.sv
hdl/saturn_debug_top.sv
test/tb_saturn_debug.sv

/* hdl/saturn_cpu_pkg.sv */
// Core-side definitions for the Saturn debug trace.
// Holds the clock phase count and the control-unit snapshot.

`default_nettype none

package saturn_cpu_pkg;

    // One machine cycle is four clock phases.
    localparam int unsigned phase_count = 4;

    // The last phase of a machine cycle, when the control unit reports a decode.
    localparam int unsigned trigger_phase = phase_count - 1;

    // Decoded instruction state as the control unit presents it.
    typedef struct packed {
        logic        instr_decoded;  // High when the fields below are valid.
        logic [19:0] current_pc;     // Address of the decoded instruction.
        logic        carry;
        logic [4:0]  alu_opcode;
        logic [4:0]  alu_reg_dest;
        logic [4:0]  alu_reg_src_1;
        logic [4:0]  alu_reg_src_2;
        logic [3:0]  alu_imm_value;  // Immediate nibble.
    } ctl_snapshot_t;

endpackage

`default_nettype wire

/* hdl/saturn_dbg_line_buffer.sv */
// Trace line buffer.
// Stores one formatted line and serves it with its status as a Wishbone classic slave.

`timescale 1ns/100ps
`default_nettype none

module saturn_dbg_line_buffer (
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire saturn_dbg_pkg::buf_wr_t i_buf_wr,
    output logic                    o_buf_ready,
    input  wire saturn_dbg_pkg::wb_req_t i_wb,
    output saturn_dbg_pkg::wb_rsp_t o_wb
);

    logic [7:0]  mem [0:63];  // Character storage.
    logic [15:0] line_ctr;    // Completed lines since reset.
    logic        ack_q;
    logic [31:0] rdata_q;
    logic        wb_req;
    logic        is_chars;
    logic [5:0]  char_idx;
    logic [31:0] rdata;

    // A request is taken once, in the cycle before its ack.
    assign wb_req   = i_wb.cyc && i_wb.stb && !ack_q;
    assign is_chars = (i_wb.adr >= saturn_dbg_pkg::adr_chars)
                      && (i_wb.adr < saturn_dbg_pkg::adr_chars + 8'(saturn_dbg_pkg::line_len));
    assign char_idx = 6'(i_wb.adr - saturn_dbg_pkg::adr_chars);

    // Read decode.
    always_comb begin
        rdata = 32'd0;  // Unmapped addresses read as zero.
        if (i_wb.adr == saturn_dbg_pkg::adr_status) begin
            rdata = {line_ctr, 8'(saturn_dbg_pkg::line_len), 7'd0, o_buf_ready};
        end else if (is_chars) begin
            rdata = {24'd0, mem[char_idx]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_buf_wr.en) begin
            mem[i_buf_wr.idx] <= i_buf_wr.char;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_buf_ready <= 1'b0;
            line_ctr    <= 16'd0;
            ack_q       <= 1'b0;
        end else begin
            ack_q <= wb_req;  // Single-cycle pulse, one cycle after the request.
            // The host releases the line by writing 1 to bit 0 of the status word.
            if (wb_req && i_wb.we && (i_wb.adr == saturn_dbg_pkg::adr_status) && i_wb.dat[0]) begin
                o_buf_ready <= 1'b0;
            end
            if (i_buf_wr.en && i_buf_wr.last) begin
                o_buf_ready <= 1'b1;
                line_ctr    <= line_ctr + 16'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wb_req) begin
            rdata_q <= rdata;
        end
    end

    always_comb begin
        o_wb.ack = ack_q;
        o_wb.dat = rdata_q;
    end

    // A held request must not be acknowledged twice.
    a_ack_pulse: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wb.ack |=> !o_wb.ack
    );

endmodule

`default_nettype wire

/* hdl/saturn_dbg_pkg.sv */
// Debug-side definitions for the Saturn trace line.
// Holds the Wishbone structs, the register map, the line layout and the formatter states.

`default_nettype none

package saturn_dbg_pkg;

    // Characters in one trace line.
    localparam int unsigned line_len = 51;

    // Wishbone register map.
    localparam logic [7:0] adr_status = 8'h00;  // Ready, length and line count.
    localparam logic [7:0] adr_chars  = 8'h40;  // First character of the line.

    // Upper-case hex digits, indexed by nibble value.
    localparam logic [15:0][7:0] hex_table = "FEDCBA9876543210";

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // One character from the formatter into the line buffer.
    typedef struct packed {
        logic       en;    // Write strobe.
        logic [5:0] idx;   // Position in the line.
        logic [7:0] char;
        logic       last;  // Final character of the line.
    } buf_wr_t;

    // Fields of the trace line, in the order they are written.
    typedef enum logic [3:0] {
        PC_LABEL,
        PC_VALUE,
        CARRY,
        OPCODE,
        DEST,
        SRC1,
        SRC2,
        IMM,
        IDLE
    } fmt_state_t;

endpackage

`default_nettype wire

/* hdl/saturn_debug_top.sv */
// Saturn debug-trace subsystem.
// Ties the phase generator, the trace debugger and the host-facing line buffer together.

`timescale 1ns/100ps
`default_nettype none

module saturn_debug_top (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire saturn_cpu_pkg::ctl_snapshot_t i_ctl,
    output logic [3:0]                    o_phases,
    output logic [31:0]                   o_cycle_ctr,
    output logic                          o_debug_cycle,
    input  wire saturn_dbg_pkg::wb_req_t  i_wb,
    output saturn_dbg_pkg::wb_rsp_t       o_wb
);

    saturn_dbg_pkg::buf_wr_t buf_wr;     // Formatter to buffer.
    logic                    buf_ready;  // Line held for the host.

    // The phase number is only needed inside the generator.
    saturn_phase_gen saturn_phase_gen_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_debug_cycle (o_debug_cycle),
        .o_phases      (o_phases),
        .o_phase       (),
        .o_cycle_ctr   (o_cycle_ctr)
    );

    saturn_debugger saturn_debugger_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_phases      (o_phases),
        .i_ctl         (i_ctl),
        .i_buf_ready   (buf_ready),
        .o_debug_cycle (o_debug_cycle),
        .o_buf_wr      (buf_wr)
    );

    saturn_dbg_line_buffer saturn_dbg_line_buffer_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_buf_wr    (buf_wr),
        .o_buf_ready (buf_ready),
        .i_wb        (i_wb),
        .o_wb        (o_wb)
    );

endmodule

`default_nettype wire

/* hdl/saturn_debugger.sv */
// Saturn trace debugger.
// Stalls the core on each decoded instruction and writes one formatted ASCII line.

`timescale 1ns/100ps
`default_nettype none

module saturn_debugger (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire [3:0]                     i_phases,
    input  wire saturn_cpu_pkg::ctl_snapshot_t i_ctl,
    input  wire                           i_buf_ready,
    output logic                          o_debug_cycle,
    output saturn_dbg_pkg::buf_wr_t       o_buf_wr
);

    saturn_cpu_pkg::ctl_snapshot_t snap;   // Values printed in this line.
    saturn_dbg_pkg::fmt_state_t    state;  // Field being written.
    logic [3:0] pos;       // Character position inside the field.
    logic [5:0] idx;       // Character position inside the line.
    logic [3:0] last_pos;  // Final position of the current field.
    logic [7:0] wr_char;
    logic       trigger;
    logic       advance;
    logic       field_done;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return saturn_dbg_pkg::hex_table[nib];
    endfunction

    function automatic saturn_dbg_pkg::fmt_state_t next_field(
        input saturn_dbg_pkg::fmt_state_t s
    );
        case (s)
            saturn_dbg_pkg::PC_LABEL: return saturn_dbg_pkg::PC_VALUE;
            saturn_dbg_pkg::PC_VALUE: return saturn_dbg_pkg::CARRY;
            saturn_dbg_pkg::CARRY:    return saturn_dbg_pkg::OPCODE;
            saturn_dbg_pkg::OPCODE:   return saturn_dbg_pkg::DEST;
            saturn_dbg_pkg::DEST:     return saturn_dbg_pkg::SRC1;
            saturn_dbg_pkg::SRC1:     return saturn_dbg_pkg::SRC2;
            saturn_dbg_pkg::SRC2:     return saturn_dbg_pkg::IMM;
            default:                  return saturn_dbg_pkg::IDLE;  // IMM closes the line.
        endcase
    endfunction

    // A decode reported in the last phase starts a trace, unless one is already running.
    assign trigger = i_phases[saturn_cpu_pkg::trigger_phase] && i_ctl.instr_decoded
                     && !o_debug_cycle;
    assign advance    = o_debug_cycle && !i_buf_ready;  // Wait while the host holds the line.
    assign field_done = (pos == last_pos);

    // Character for the current field and position. 5-bit fields print as two digits.
    always_comb begin
        wr_char  = " ";  // Separators and padding.
        last_pos = 4'd0;
        case (state)
            saturn_dbg_pkg::PC_LABEL: begin
                last_pos = 4'd3;
                case (pos)
                    4'd0:    wr_char = "P";
                    4'd1:    wr_char = "C";
                    4'd2:    wr_char = ":";
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::PC_VALUE: begin
                last_pos = 4'd5;
                case (pos)
                    4'd0:    wr_char = hex_char(snap.current_pc[19:16]);  // Most significant first.
                    4'd1:    wr_char = hex_char(snap.current_pc[15:12]);
                    4'd2:    wr_char = hex_char(snap.current_pc[11:8]);
                    4'd3:    wr_char = hex_char(snap.current_pc[7:4]);
                    4'd4:    wr_char = hex_char(snap.current_pc[3:0]);
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::CARRY: begin
                last_pos = 4'd8;
                case (pos)
                    4'd0:    wr_char = "C";
                    4'd1:    wr_char = "a";
                    4'd2:    wr_char = "r";
                    4'd3:    wr_char = "r";
                    4'd4:    wr_char = "y";
                    4'd5:    wr_char = ":";
                    4'd7:    wr_char = hex_char({3'b000, snap.carry});
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::OPCODE: begin
                last_pos = 4'd6;
                case (pos)
                    4'd0:    wr_char = "O";
                    4'd1:    wr_char = "P";
                    4'd2:    wr_char = ":";
                    4'd4:    wr_char = hex_char({3'b000, snap.alu_opcode[4]});
                    4'd5:    wr_char = hex_char(snap.alu_opcode[3:0]);
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::DEST: begin
                last_pos = 4'd5;  // The label is one character shorter here.
                case (pos)
                    4'd0:    wr_char = "D";
                    4'd1:    wr_char = ":";
                    4'd3:    wr_char = hex_char({3'b000, snap.alu_reg_dest[4]});
                    4'd4:    wr_char = hex_char(snap.alu_reg_dest[3:0]);
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::SRC1: begin
                last_pos = 4'd6;
                case (pos)
                    4'd0:    wr_char = "S";
                    4'd1:    wr_char = "1";
                    4'd2:    wr_char = ":";
                    4'd4:    wr_char = hex_char({3'b000, snap.alu_reg_src_1[4]});
                    4'd5:    wr_char = hex_char(snap.alu_reg_src_1[3:0]);
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::SRC2: begin
                last_pos = 4'd6;
                case (pos)
                    4'd0:    wr_char = "S";
                    4'd1:    wr_char = "2";
                    4'd2:    wr_char = ":";
                    4'd4:    wr_char = hex_char({3'b000, snap.alu_reg_src_2[4]});
                    4'd5:    wr_char = hex_char(snap.alu_reg_src_2[3:0]);
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::IMM: begin
                last_pos = 4'd4;  // No trailing space at the end of the line.
                case (pos)
                    4'd0:    wr_char = "I";
                    4'd1:    wr_char = "M";
                    4'd2:    wr_char = ":";
                    4'd4:    wr_char = hex_char(snap.alu_imm_value);
                    default: wr_char = " ";
                endcase
            end
            default: begin
                last_pos = 4'd0;  // Idle writes nothing.
            end
        endcase
    end

    always_comb begin
        o_buf_wr.en   = advance;
        o_buf_wr.idx  = idx;
        o_buf_wr.char = wr_char;
        o_buf_wr.last = (state == saturn_dbg_pkg::IMM) && field_done;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_debug_cycle <= 1'b0;
            state         <= saturn_dbg_pkg::IDLE;
            pos           <= 4'd0;
            idx           <= 6'd0;
        end else if (trigger) begin
            o_debug_cycle <= 1'b1;  // Core stalls from the next cycle.
            state         <= saturn_dbg_pkg::PC_LABEL;
            pos           <= 4'd0;
            idx           <= 6'd0;
        end else if (advance) begin
            idx <= idx + 6'd1;
            if (field_done) begin
                pos   <= 4'd0;
                state <= next_field(state);
                if (state == saturn_dbg_pkg::IMM) begin
                    o_debug_cycle <= 1'b0;  // The whole line is written, so the core runs again.
                end
            end else begin
                pos <= pos + 4'd1;
            end
        end
    end

    // Snapshot taken at the trigger edge.
    always_ff @(posedge i_clk) begin
        if (trigger) begin
            snap <= i_ctl;
        end
    end

    a_idx_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_buf_wr.en |-> (o_buf_wr.idx < 6'(saturn_dbg_pkg::line_len))
    );

    // The field walk has to land on the final column exactly when last is flagged.
    a_last_idx: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_buf_wr.en && o_buf_wr.last) |-> (o_buf_wr.idx == 6'(saturn_dbg_pkg::line_len - 1))
    );

endmodule

`default_nettype wire

/* hdl/saturn_phase_gen.sv */
// Saturn clock phase generator.
// Rotates the one-hot phases, counts machine cycles and freezes during a debug cycle.

`timescale 1ns/100ps
`default_nettype none

module saturn_phase_gen (
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire         i_debug_cycle,
    output logic [3:0]  o_phases,
    output logic [1:0]  o_phase,
    output logic [31:0] o_cycle_ctr
);

    logic phase_wrap;

    // The machine cycle ends on the last phase.
    assign phase_wrap = (o_phase == 2'(saturn_cpu_pkg::phase_count - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_phases    <= 4'b0001;
            o_phase     <= 2'd0;
            o_cycle_ctr <= 32'd0;
        end else if (!i_debug_cycle) begin
            o_phases <= {o_phases[2:0], o_phases[3]};  // Rotate towards the next phase.
            o_phase  <= o_phase + 2'd1;                // Wraps naturally from 3 to 0.
            if (phase_wrap) begin
                o_cycle_ctr <= o_cycle_ctr + 32'd1;
            end
        end
        // Both hold their value while the debugger owns the core.
    end

    // The one-hot vector and the phase number must always describe the same phase.
    a_phase_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot(o_phases) && (o_phases == (4'b0001 << o_phase))
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the trace testbench with Verilator. Exit status 1 on failure.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_saturn_debug -f compile.f \
    -o tb_saturn_debug > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_saturn_debug > sim.log 2>&1
cat sim.log
! grep -q "TESTS FAILED" sim.log && grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

/* test/tb_saturn_debug.sv */
// Testbench for the Saturn debug-trace subsystem.
// Acts as the control unit and the Wishbone host. Concurrent assertions check the DUT.

`timescale 1ns/100ps
`default_nettype none

module tb_saturn_debug;

    // The tests take about 500 cycles, so the limit leaves a wide margin.
    localparam int timeout_cycles = 5000;

    logic                          i_clk = 1'b0;
    logic                          i_reset;
    saturn_cpu_pkg::ctl_snapshot_t i_ctl;
    logic [3:0]                    o_phases;
    logic [31:0]                   o_cycle_ctr;
    logic                          o_debug_cycle;
    saturn_dbg_pkg::wb_req_t       i_wb;
    saturn_dbg_pkg::wb_rsp_t       o_wb;

    integer        seed = 32'h83fa8932;
    int            cycles = 0;
    int            dbg_len = 0;     // Cycles spent in the current debug cycle.
    logic [31:0]   exp_rd;          // Expected data of the pending read.
    logic          rd_check;
    logic          hold_line;       // Host still holds the previous line.
    logic          bp_test;
    logic          prev_reset = 1'b0;
    logic          prev_dbg = 1'b0;
    logic          prev_req = 1'b0;
    logic [3:0]    prev_phases = 4'd0;
    logic [31:0]   prev_ctr = 32'd0;
    saturn_cpu_pkg::ctl_snapshot_t snap_a;
    saturn_cpu_pkg::ctl_snapshot_t snap_b;

    saturn_debug_top saturn_debug_top_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_ctl         (i_ctl),
        .o_phases      (o_phases),
        .o_cycle_ctr   (o_cycle_ctr),
        .o_debug_cycle (o_debug_cycle),
        .i_wb          (i_wb),
        .o_wb          (o_wb)
    );

    always #4 i_clk = ~i_clk;  // 8 ns period.

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // Copies of the outputs from the last cycle serve as the reference for the step checks.
    always @(posedge i_clk) begin
        cycles      <= cycles + 1;
        prev_reset  <= i_reset;
        prev_dbg    <= o_debug_cycle;
        prev_req    <= i_wb.cyc && i_wb.stb;
        prev_phases <= o_phases;
        prev_ctr    <= o_cycle_ctr;
        dbg_len     <= o_debug_cycle ? dbg_len + 1 : 0;
        if (cycles >= timeout_cycles) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycles));
        end
    end

    a_reset_values: assert property (@(posedge i_clk) prev_reset |->
        (o_phases == 4'b0001 && o_cycle_ctr == 32'd0 && !o_debug_cycle && !o_wb.ack))
        else fail_run($sformatf(
            "mismatch after reset: o_phases 0x%h o_cycle_ctr 0x%h o_debug_cycle 0x%h ack 0x%h",
            $sampled(o_phases), $sampled(o_cycle_ctr), $sampled(o_debug_cycle),
            $sampled(o_wb.ack)));

    // A free-running clock moves one phase and counts the wrap out of phase 3.
    a_phase_step: assert property (@(posedge i_clk) disable iff (i_reset)
        (!prev_reset && !prev_dbg) |-> o_phases == {prev_phases[2:0], prev_phases[3]})
        else fail_run($sformatf("mismatch o_phases: got 0x%h expected 0x%h",
            $sampled(o_phases), {$sampled(prev_phases[2:0]), $sampled(prev_phases[3])}));
    a_cycle_step: assert property (@(posedge i_clk) disable iff (i_reset)
        (!prev_reset && !prev_dbg)
        |-> o_cycle_ctr == prev_ctr + (prev_phases[3] ? 32'd1 : 32'd0))
        else fail_run($sformatf("mismatch o_cycle_ctr: got 0x%h after 0x%h",
            $sampled(o_cycle_ctr), $sampled(prev_ctr)));
    a_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        (!prev_reset && prev_dbg) |-> (o_phases == prev_phases && o_cycle_ctr == prev_ctr))
        else fail_run($sformatf("mismatch in stall: o_phases 0x%h o_cycle_ctr 0x%h, held 0x%h 0x%h",
            $sampled(o_phases), $sampled(o_cycle_ctr), $sampled(prev_phases),
            $sampled(prev_ctr)));

    a_trigger: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_phases[3] && i_ctl.instr_decoded && !o_debug_cycle) |=> o_debug_cycle)
        else fail_run("o_debug_cycle did not rise after a decode in phase 3");
    a_hold: assert property (@(posedge i_clk) disable iff (i_reset) hold_line |-> o_debug_cycle)
        else fail_run("o_debug_cycle fell while the host still held the previous line");
    // A free buffer takes one character per cycle. A held one stretches the stall.
    a_dbg_len: assert property (@(posedge i_clk) disable iff (i_reset)
        (prev_dbg && !o_debug_cycle) |-> (bp_test ? dbg_len > 51 : dbg_len == 51))
        else fail_run($sformatf("mismatch debug cycle length: got 0x%h", $sampled(dbg_len)));

    a_ack_delay: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb.cyc && i_wb.stb && !o_wb.ack) |=> o_wb.ack)
        else fail_run("a Wishbone request got no ack in the next cycle");
    a_ack_pulse: assert property (@(posedge i_clk) disable iff (i_reset) o_wb.ack |=> !o_wb.ack)
        else fail_run("ack stayed high for more than one cycle");
    a_ack_cause: assert property (@(posedge i_clk) disable iff (i_reset) o_wb.ack |-> prev_req)
        else fail_run("ack arrived without a request");
    a_rd_data: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_wb.ack && rd_check) |-> o_wb.dat == exp_rd)
        else fail_run($sformatf("mismatch o_wb.dat at adr 0x%h: got 0x%h expected 0x%h",
            $sampled(i_wb.adr), $sampled(o_wb.dat), $sampled(exp_rd)));

    // Upper-case hex with the most significant nibble first.
    function automatic string hex_text(input logic [19:0] v, input int digits);
        string tbl;
        string s;
        int    nib;
        tbl = "0123456789ABCDEF";
        s   = "";
        for (int i = digits - 1; i >= 0; i--) begin
            nib = int'(v[i*4 +: 4]);
            s   = {s, tbl.substr(nib, nib)};
        end
        return s;
    endfunction

    function automatic string format_line(input saturn_cpu_pkg::ctl_snapshot_t s);
        return {"PC: ", hex_text(s.current_pc, 5), " Carry: ", hex_text(20'(s.carry), 1),
                " OP: ", hex_text(20'(s.alu_opcode), 2), " D: ", hex_text(20'(s.alu_reg_dest), 2),
                " S1: ", hex_text(20'(s.alu_reg_src_1), 2),
                " S2: ", hex_text(20'(s.alu_reg_src_2), 2),
                " IM: ", hex_text(20'(s.alu_imm_value), 1)};
    endfunction

    function automatic logic [31:0] status_word(input logic ready, input logic [15:0] count);
        return {count, 8'd51, 7'd0, ready};  // 51 characters per line.
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    // A classic cycle holds the request until ack and releases it after that edge.
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] dat);
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = we;
        i_wb.adr = adr;
        i_wb.dat = we ? dat : 32'd0;
        exp_rd   = dat;
        rd_check = !we;
        do next_cycle(); while (!o_wb.ack);
        next_cycle();
        i_wb     = '0;
        rd_check = 1'b0;
    endtask

    task automatic draw_snapshot(output saturn_cpu_pkg::ctl_snapshot_t s);
        logic [63:0] raw;
        raw = {$random(seed), $random(seed)};
        s   = raw[$bits(saturn_cpu_pkg::ctl_snapshot_t)-1:0];
        s.instr_decoded = 1'b1;
    endtask

    // Present the decode so that it is sampled while phase 3 is active.
    task automatic trigger_snapshot(input saturn_cpu_pkg::ctl_snapshot_t s);
        while (!o_phases[3]) next_cycle();
        i_ctl = s;
        next_cycle();
        i_ctl.instr_decoded = 1'b0;
    endtask

    task automatic check_line(input saturn_cpu_pkg::ctl_snapshot_t s, input logic [15:0] count);
        string line;
        line = format_line(s);
        wb_access(1'b0, saturn_dbg_pkg::adr_status, {count, 8'(line.len()), 7'd0, 1'b1});
        for (int n = 0; n < line.len(); n++) begin
            wb_access(1'b0, saturn_dbg_pkg::adr_chars + 8'(n), {24'd0, line[n]});
        end
    endtask

    initial begin
        i_reset   = 1'b1;
        i_ctl     = '0;
        i_wb      = '0;
        exp_rd    = 32'd0;
        rd_check  = 1'b0;
        hold_line = 1'b0;
        bp_test   = 1'b0;
        repeat (8) @(posedge i_clk);
        #1 i_reset = 1'b0;
        repeat (12) next_cycle();  // Free-running phases.
        wb_access(1'b0, saturn_dbg_pkg::adr_status, status_word(1'b0, 16'd0));
        draw_snapshot(snap_a);
        trigger_snapshot(snap_a);
        while (o_debug_cycle) next_cycle();
        check_line(snap_a, 16'd1);
        wb_access(1'b0, 8'h73, 32'd0);  // Just past the last character.
        wb_access(1'b0, 8'h3f, 32'd0);
        wb_access(1'b0, 8'h04, 32'd0);
        // Second decode while the first line is still held.
        bp_test = 1'b1;
        draw_snapshot(snap_b);
        trigger_snapshot(snap_b);
        hold_line = 1'b1;
        repeat (10) next_cycle();
        check_line(snap_a, 16'd1);
        wb_access(1'b1, saturn_dbg_pkg::adr_status, 32'd1);
        hold_line = 1'b0;
        while (o_debug_cycle) next_cycle();
        check_line(snap_b, 16'd2);
        wb_access(1'b1, saturn_dbg_pkg::adr_status, 32'd1);
        wb_access(1'b0, saturn_dbg_pkg::adr_status, status_word(1'b0, 16'd2));
        repeat (12) next_cycle();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
